// File: Makefile
# Verilator build and run of the dcache testbench

VERILATOR ?= verilator
FILELIST  ?= dcache_top.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in log"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only hdl/dcache_pkg.sv hdl/dcache_req_buffer.sv \
		hdl/dcache_ctrl_fsm.sv hdl/dcache_ways.sv hdl/dcache_read_mux.sv \
		hdl/dcache_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/dcache_checker.sv
// dcache checker: shadow memory and comparison of read responses and bus writes
module dcache_checker (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    input  logic              req_ready,
    input  logic              req_wr,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    input  logic              resp_valid,
    input  dcache_pkg::word_t resp_rdata,
    input  logic              mem_req,
    input  logic              mem_wr,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::strb_t mem_wstrb,
    input  logic              mem_addr_ok,
    output int                errors,
    output int                checks,
    output int                outstanding
);

    dcache_pkg::word_t shadow [1024];
    dcache_pkg::word_t exp_rdata [$];
    dcache_pkg::addr_t exp_waddr [$];
    dcache_pkg::word_t exp_wdata [$];
    dcache_pkg::strb_t exp_wstrb [$];

    function automatic dcache_pkg::word_t fill_word(dcache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic dcache_pkg::word_t merge_strobes(dcache_pkg::word_t old_word,
            dcache_pkg::word_t new_word, dcache_pkg::strb_t strb);
        dcache_pkg::word_t res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = strb[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return res;
    endfunction

    // reference: what memory holds at this address after all writes so far
    function automatic dcache_pkg::word_t expected_word(dcache_pkg::addr_t a);
        return shadow[a[11:2]];
    endfunction

    initial begin
        errors      = 0;
        checks      = 0;
        outstanding = 0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = fill_word(32'(i) << 2);
        end
    end

    function automatic void compare(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED time=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endfunction

    ////////////////////////////////////////
    // sampled on the edge, before updates
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rstn) begin
            // responses first, a hit can retire and accept on the same edge
            if (resp_valid) begin
                if (exp_rdata.size() == 0) begin
                    errors++;
                    $display("read response at %0t with no outstanding read", $time);
                end else begin
                    compare("resp_rdata", exp_rdata.pop_front(), resp_rdata);
                end
            end
            if (mem_req && mem_wr && mem_addr_ok) begin
                if (exp_waddr.size() == 0) begin
                    errors++;
                    $display("bus write at %0t with no write request behind it", $time);
                end else begin
                    compare("mem_addr", exp_waddr.pop_front(), mem_addr);
                    compare("mem_wdata", exp_wdata.pop_front(), mem_wdata);
                    compare("mem_wstrb", 32'(exp_wstrb.pop_front()), 32'(mem_wstrb));
                end
            end
            if (req_valid && req_ready) begin
                if (req_wr) begin
                    shadow[req_addr[11:2]] = merge_strobes(expected_word(req_addr),
                                                           req_wdata, req_wstrb);
                    exp_waddr.push_back(req_addr);
                    exp_wdata.push_back(req_wdata);
                    exp_wstrb.push_back(req_wstrb);
                end else begin
                    exp_rdata.push_back(expected_word(req_addr));
                end
            end
            // reads and bus writes still waiting to be seen
            outstanding = exp_rdata.size() + exp_waddr.size();
        end
    end

endmodule

// File: bench/dcache_tb.sv
// dcache testbench: clock, reset, memory model, directed and random traffic
module dcache_tb;

    localparam int limit = 200;

    logic              clk = 1'b0;
    logic              rstn;
    logic              req_valid, req_ready, req_wr, resp_valid;
    dcache_pkg::addr_t req_addr, mem_addr;
    dcache_pkg::word_t req_wdata, resp_rdata, mem_wdata;
    dcache_pkg::strb_t req_wstrb, mem_wstrb;
    logic              mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    logic [127:0]      mem_rdata;

    dcache_pkg::word_t mem_words [1024];
    integer            seed = 32'h2b29_14fa;
    int                addr_cnt, data_cnt, mem_reads, tb_errors, mark;
    logic              read_pending;
    dcache_pkg::addr_t read_addr;
    int                chk_errors, chk_checks, chk_outstanding;

    always #5 clk = ~clk;

    dcache_top u_dut (.*);

    dcache_checker u_chk (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready),
        .req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_wstrb(req_wstrb), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok),
        .errors(chk_errors), .checks(chk_checks), .outstanding(chk_outstanding)
    );

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            mem_addr_ok  <= 1'b0;
            mem_data_ok  <= 1'b0;
            read_pending <= 1'b0;
        end else begin
            if (mem_req && mem_addr_ok) begin
                mem_addr_ok <= 1'b0;
                addr_cnt    <= $unsigned($random(seed)) % 4;
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            mem_words[mem_addr[11:2]][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                        end
                    end
                end else begin
                    read_pending <= 1'b1;
                    read_addr    <= mem_addr;
                    data_cnt     <= $unsigned($random(seed)) % 4;
                    mem_reads    <= mem_reads + 1;
                end
            end else if (mem_req) begin
                if (addr_cnt == 0) mem_addr_ok <= 1'b1;
                else addr_cnt <= addr_cnt - 1;
            end
            if (mem_data_ok) begin
                mem_data_ok <= 1'b0;
            end else if (read_pending) begin
                if (data_cnt == 0) begin
                    for (int k = 0; k < 4; k++) begin
                        mem_rdata[k*32 +: 32] <= mem_words[read_addr[11:2] + 10'(k)];
                    end
                    mem_data_ok  <= 1'b1;
                    read_pending <= 1'b0;
                end else begin
                    data_cnt <= data_cnt - 1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic stop_on_timeout(string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_level(string name, logic exp, logic got);
        if (got !== exp) begin
            tb_errors++;
            $display("FAILED time=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic send_request(logic wr, dcache_pkg::addr_t a, dcache_pkg::word_t d,
                                dcache_pkg::strb_t s);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_wr    <= wr;
        req_addr  <= a;
        req_wdata <= d;
        req_wstrb <= s;
        do begin
            @(negedge clk);
            n++;
        end while (!req_ready && n < limit);
        if (!req_ready) begin
            stop_on_timeout("req_ready");
        end else begin
            @(posedge clk);
            req_valid <= 1'b0;
            // completion: a response for reads, ready again for writes
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!(wr ? req_ready : resp_valid) && n < limit);
            if (!(wr ? req_ready : resp_valid)) begin
                stop_on_timeout("request completion");
            end
        end
    endtask

    // two reads on consecutive edges, both expected to hit
    task automatic read_back_to_back(dcache_pkg::addr_t a0, dcache_pkg::addr_t a1);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_wr    <= 1'b0;
        req_addr  <= a0;
        do begin
            @(negedge clk);
            n++;
        end while (!req_ready && n < limit);
        if (!req_ready) begin
            stop_on_timeout("req_ready");
        end else begin
            @(posedge clk);
            req_addr <= a1;
            // hit answers in lookup and takes the next request there
            @(negedge clk);
            check_level("resp_valid", 1'b1, resp_valid);
            check_level("req_ready", 1'b1, req_ready);
            @(posedge clk);
            req_valid <= 1'b0;
            @(negedge clk);
            check_level("resp_valid", 1'b1, resp_valid);
        end
    endtask

    task automatic expect_reads(int delta, string step);
        if (mem_reads - mark != delta) begin
            tb_errors++;
            $display("FAILED time=%0t mem_reads (%s) expected %0d got %0d",
                     $time, step, delta, mem_reads - mark);
        end
        mark = mem_reads;
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = (32'(i << 2) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        end
        rstn        = 1'b0;
        req_valid   = 1'b0;
        req_wr      = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wstrb   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        addr_cnt    = 0;
        data_cnt    = 0;
        mem_reads   = 0;
        tb_errors   = 0;
        mark        = 0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_level("req_ready", 1'b1, req_ready);
        check_level("mem_req", 1'b0, mem_req);
        check_level("resp_valid", 1'b0, resp_valid);
        // first read misses, second word of the line hits
        send_request(1'b0, 32'h0000_0010, '0, '0);
        expect_reads(1, "first read");
        send_request(1'b0, 32'h0000_0014, '0, '0);
        expect_reads(0, "same line");
        read_back_to_back(32'h0000_001c, 32'h0000_0010);
        expect_reads(0, "back to back hits");
        // partial write hit, then read back from the cache
        send_request(1'b1, 32'h0000_0018, 32'hdead_beef, 4'b0101);
        send_request(1'b0, 32'h0000_0018, '0, '0);
        expect_reads(0, "write hit");
        // write miss does not allocate
        send_request(1'b1, 32'h0000_0204, 32'h1234_5678, 4'b1111);
        expect_reads(0, "write miss");
        send_request(1'b0, 32'h0000_0204, '0, '0);
        expect_reads(1, "read after write miss");
        // A, B, A, C in set 5 evicts B
        send_request(1'b0, 32'h0000_0050, '0, '0);
        send_request(1'b0, 32'h0000_0150, '0, '0);
        send_request(1'b0, 32'h0000_0054, '0, '0);
        send_request(1'b0, 32'h0000_0250, '0, '0);
        expect_reads(3, "A B A C");
        send_request(1'b0, 32'h0000_0058, '0, '0);
        expect_reads(0, "A stays");
        send_request(1'b0, 32'h0000_0158, '0, '0);
        expect_reads(1, "B evicted");
        repeat (300) begin
            send_request(1'($random(seed)), 32'($unsigned($random(seed)) % 256) << 2,
                         $random(seed), 4'($random(seed)));
        end
        repeat (5) @(posedge clk);
        if (chk_outstanding != 0) begin
            tb_errors++;
            $display("%0d expected reads or bus writes never came", chk_outstanding);
        end
        $display("checks %0d, checker errors %0d, bench errors %0d, memory reads %0d",
                 chk_checks, chk_errors, tb_errors, mem_reads);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_req_buffer.sv
hdl/dcache_ctrl_fsm.sv
hdl/dcache_ways.sv
hdl/dcache_read_mux.sv
hdl/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

// File: hdl/dcache_ctrl_fsm.sv
// dcache controller FSM: pipeline handshake, memory requests and array write controls
module dcache_ctrl_fsm (
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_valid,
    output logic       req_ready,
    input  logic       buf_wr,
    input  logic [1:0] hit,
    input  logic       victim,
    input  logic       mem_addr_ok,
    input  logic       mem_data_ok,
    output logic       mem_req,
    output logic       mem_wr,
    output logic       load,
    output logic [1:0] way_we,
    output logic       refill,
    output logic       touch,
    output logic       sel_way,
    output logic       sel_refill,
    output logic       resp_fire
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e next_state;
    dcache_pkg::ctrl_state_e accept_state;

    logic any_hit;

    assign any_hit = |hit;

    // where to go from a cycle that can take a new request
    assign accept_state = req_valid ? dcache_pkg::lookup : dcache_pkg::idle;

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        req_ready  = 1'b0;
        load       = 1'b0;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        way_we     = 2'b00;
        refill     = 1'b0;
        touch      = 1'b0;
        sel_way    = 1'b0;
        sel_refill = 1'b0;
        resp_fire  = 1'b0;

        case (state)
            dcache_pkg::idle: begin
                req_ready  = 1'b1;
                load       = req_valid;
                next_state = accept_state;
            end

            dcache_pkg::lookup: begin
                if (any_hit && buf_wr) begin
                    // update the hit line now, then write through
                    way_we     = hit;
                    next_state = dcache_pkg::mem_write;
                end else if (any_hit) begin
                    // read hit returns now and takes the next request
                    touch      = 1'b1;
                    sel_way    = hit[1];
                    resp_fire  = 1'b1;
                    req_ready  = 1'b1;
                    load       = req_valid;
                    next_state = accept_state;
                end else if (buf_wr) begin
                    // no write-allocate
                    next_state = dcache_pkg::mem_write;
                end else begin
                    next_state = dcache_pkg::miss_read;
                end
            end

            dcache_pkg::miss_read: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = dcache_pkg::miss_wait;
                end
            end

            dcache_pkg::miss_wait: begin
                if (mem_data_ok) begin
                    // fill the LRU way and forward the word from the block
                    refill     = 1'b1;
                    way_we     = victim ? 2'b10 : 2'b01;
                    sel_refill = 1'b1;
                    resp_fire  = 1'b1;
                    req_ready  = 1'b1;
                    load       = req_valid;
                    next_state = accept_state;
                end
            end

            dcache_pkg::mem_write: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                // write is done once the address is taken
                if (mem_addr_ok) begin
                    req_ready  = 1'b1;
                    load       = req_valid;
                    next_state = accept_state;
                end
            end

            default: begin
                next_state = dcache_pkg::idle;
            end
        endcase
    end

endmodule

// File: hdl/dcache_pkg.sv
// dcache shared types: data word, byte address, write strobes and controller states
package dcache_pkg;

    ////////////////////////////////////////
    // bus and pipeline types
    ////////////////////////////////////////

    // one data word as seen by the pipeline and the memory bus
    typedef logic [31:0] word_t;

    // byte address, word aligned accesses only
    typedef logic [31:0] addr_t;

    // byte write enables, one per byte of word_t
    typedef logic [3:0] strb_t;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    // idle       waiting for a request
    // lookup     tag compare on the buffered request
    // miss_read  line address on the bus, waiting for addr_ok
    // miss_wait  waiting for the refill block
    // mem_write  write-through, waiting for addr_ok
    typedef enum logic [2:0] {
        idle      = 3'd0,
        lookup    = 3'd1,
        miss_read = 3'd2,
        miss_wait = 3'd3,
        mem_write = 3'd4
    } ctrl_state_e;

endpackage

// File: hdl/dcache_read_mux.sv
// dcache read mux: picks the returned word from the hit way or the refill block
module dcache_read_mux #(
    parameter int offset_width = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rstn,
    input  logic                                                   sel_way,
    input  logic                                                   sel_refill,
    input  logic                                                   resp_fire,
    input  dcache_pkg::word_t [1:0]                                hit_words,
    input  logic [$bits(dcache_pkg::word_t)*(2**offset_width)-1:0] mem_rdata,
    input  logic [offset_width-1:0]                                buf_offset,
    output logic                                                   resp_valid,
    output dcache_pkg::word_t                                      resp_rdata
);

    localparam int word_width = $bits(dcache_pkg::word_t);

    dcache_pkg::word_t sel_word;
    dcache_pkg::word_t last_rdata;

    // refill forwards straight from the incoming block
    assign sel_word = sel_refill ? mem_rdata[buf_offset*word_width +: word_width]
                                 : hit_words[sel_way];

    // last returned word, shown while no response is going out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_rdata <= '0;
        end else if (resp_fire) begin
            last_rdata <= sel_word;
        end
    end

    assign resp_valid = resp_fire;
    assign resp_rdata = resp_fire ? sel_word : last_rdata;

endmodule

// File: hdl/dcache_req_buffer.sv
// dcache request buffer: holds the accepted request and splits its address into fields
module dcache_req_buffer #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   load,
    input  logic                                   req_wr,
    input  dcache_pkg::addr_t                      req_addr,
    input  dcache_pkg::word_t                      req_wdata,
    input  dcache_pkg::strb_t                      req_wstrb,
    output logic                                   buf_wr,
    output logic [31-2-offset_width-index_width:0] buf_tag,
    output logic [index_width-1:0]                 buf_index,
    output logic [offset_width-1:0]                buf_offset,
    output dcache_pkg::addr_t                      buf_line_addr,
    output dcache_pkg::addr_t                      buf_addr,
    output dcache_pkg::word_t                      buf_wdata,
    output dcache_pkg::strb_t                      buf_wstrb
);

    localparam int line_lsb = 2 + offset_width;
    localparam int tag_lsb  = line_lsb + index_width;

    // request type is control state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_wr <= 1'b0;
        end else if (load) begin
            buf_wr <= req_wr;
        end
    end

    // address and write payload
    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // field split
    assign buf_offset = buf_addr[2 +: offset_width];
    assign buf_index  = buf_addr[line_lsb +: index_width];
    assign buf_tag    = buf_addr[31:tag_lsb];

    // refills always start at the first word of the line
    assign buf_line_addr = {buf_addr[31:line_lsb], {line_lsb{1'b0}}};

endmodule

// File: hdl/dcache_top.sv
// dcache top: two-way write-through data cache between the pipeline and the memory bus
module dcache_top #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rstn,
    // pipeline side
    input  logic                                                   req_valid,
    input  logic                                                   req_wr,
    input  dcache_pkg::addr_t                                      req_addr,
    input  dcache_pkg::word_t                                      req_wdata,
    input  dcache_pkg::strb_t                                      req_wstrb,
    output logic                                                   req_ready,
    output logic                                                   resp_valid,
    output dcache_pkg::word_t                                      resp_rdata,
    // memory side
    output logic                                                   mem_req,
    output logic                                                   mem_wr,
    output dcache_pkg::addr_t                                      mem_addr,
    output dcache_pkg::word_t                                      mem_wdata,
    output dcache_pkg::strb_t                                      mem_wstrb,
    input  logic                                                   mem_addr_ok,
    input  logic                                                   mem_data_ok,
    input  logic [$bits(dcache_pkg::word_t)*(2**offset_width)-1:0] mem_rdata
);

    localparam int tag_width = 30 - offset_width - index_width;

    logic                    load;
    logic                    buf_wr;
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    dcache_pkg::addr_t       buf_line_addr;
    dcache_pkg::addr_t       buf_addr;
    logic [1:0]              hit;
    logic                    victim;
    logic [1:0]              way_we;
    logic                    refill;
    logic                    touch;
    logic                    sel_way;
    logic                    sel_refill;
    logic                    resp_fire;
    dcache_pkg::word_t [1:0] hit_words;

    dcache_req_buffer #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_req_buffer (
        .clk           (clk),
        .rstn          (rstn),
        .load          (load),
        .req_wr        (req_wr),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .buf_wr        (buf_wr),
        .buf_tag       (buf_tag),
        .buf_index     (buf_index),
        .buf_offset    (buf_offset),
        .buf_line_addr (buf_line_addr),
        .buf_addr      (buf_addr),
        .buf_wdata     (mem_wdata),
        .buf_wstrb     (mem_wstrb)
    );

    dcache_ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .buf_wr      (buf_wr),
        .hit         (hit),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .load        (load),
        .way_we      (way_we),
        .refill      (refill),
        .touch       (touch),
        .sel_way     (sel_way),
        .sel_refill  (sel_refill),
        .resp_fire   (resp_fire)
    );

    dcache_ways #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_ways (
        .clk        (clk),
        .rstn       (rstn),
        .buf_tag    (buf_tag),
        .buf_index  (buf_index),
        .buf_offset (buf_offset),
        .buf_wdata  (mem_wdata),
        .buf_wstrb  (mem_wstrb),
        .way_we     (way_we),
        .refill     (refill),
        .touch      (touch),
        .mem_rdata  (mem_rdata),
        .hit        (hit),
        .victim     (victim),
        .hit_words  (hit_words)
    );

    dcache_read_mux #(
        .offset_width (offset_width)
    ) u_read_mux (
        .clk        (clk),
        .rstn       (rstn),
        .sel_way    (sel_way),
        .sel_refill (sel_refill),
        .resp_fire  (resp_fire),
        .hit_words  (hit_words),
        .mem_rdata  (mem_rdata),
        .buf_offset (buf_offset),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    // reads fetch the whole line, writes go to the exact word
    assign mem_addr = mem_wr ? buf_addr : buf_line_addr;

endmodule

// File: hdl/dcache_ways.sv
// dcache ways: tag, valid and data arrays of both ways, hit compare, strobe merge and LRU
module dcache_ways #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic [31-2-offset_width-index_width:0]           buf_tag,
    input  logic [index_width-1:0]                           buf_index,
    input  logic [offset_width-1:0]                          buf_offset,
    input  dcache_pkg::word_t                                buf_wdata,
    input  dcache_pkg::strb_t                                buf_wstrb,
    input  logic [1:0]                                       way_we,
    input  logic                                             refill,
    input  logic                                             touch,
    input  logic [$bits(dcache_pkg::word_t)*(2**offset_width)-1:0] mem_rdata,
    output logic [1:0]                                       hit,
    output logic                                             victim,
    output dcache_pkg::word_t [1:0]                          hit_words
);

    localparam int tag_width      = 30 - offset_width - index_width;
    localparam int num_sets       = 2 ** index_width;
    localparam int words_per_line = 2 ** offset_width;
    localparam int word_width     = $bits(dcache_pkg::word_t);

    logic [tag_width-1:0] tag_mem [2][num_sets];
    dcache_pkg::word_t    data_mem [2][num_sets][words_per_line];

    logic [1:0][num_sets-1:0] valid_q;
    logic [num_sets-1:0]      lru_q;

    dcache_pkg::word_t [1:0] merged_word;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w]       = valid_q[w][buf_index] && (tag_mem[w][buf_index] == buf_tag);
            hit_words[w] = data_mem[w][buf_index][buf_offset];
            // byte merge of the store into the current word
            for (int b = 0; b < $bits(dcache_pkg::strb_t); b++) begin
                merged_word[w][b*8 +: 8] = buf_wstrb[b] ? buf_wdata[b*8 +: 8]
                                                        : hit_words[w][b*8 +: 8];
            end
        end
    end

    // lru bit names the way to replace next
    assign victim = lru_q[buf_index];

    ////////////////////////////////////////
    // array writes
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w] && refill) begin
                tag_mem[w][buf_index] <= buf_tag;
                for (int k = 0; k < words_per_line; k++) begin
                    data_mem[w][buf_index][k] <= mem_rdata[k*word_width +: word_width];
                end
            end else if (way_we[w]) begin
                data_mem[w][buf_index][buf_offset] <= merged_word[w];
            end
        end
    end

    // valid and lru state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (refill) begin
                for (int w = 0; w < 2; w++) begin
                    if (way_we[w]) begin
                        valid_q[w][buf_index] <= 1'b1;
                    end
                end
            end
            // point away from the way just used
            if (|way_we) begin
                lru_q[buf_index] <= way_we[0];
            end else if (touch) begin
                lru_q[buf_index] <= hit[0];
            end
        end
    end

endmodule
